/* common/cache_pkg.sv */
package cache_pkg;

	// core and L2 address width
	localparam int addr_width = 32;

	// one core word
	localparam int data_width = 32;

	// line geometry
	localparam int words_per_line = 8;
	localparam int line_width = data_width * words_per_line;	// 256 bits on the L2 port

	// address split, low to high: byte, word, index, tag
	localparam int byte_bits = 2;	// ignored, every access is a full word
	localparam int word_bits = 3;	// word within a line
	localparam int index_bits = 6;	// few sets so conflicts are easy to hit
	localparam int tag_bits = addr_width - index_bits - word_bits - byte_bits;

	localparam int num_sets = 1 << index_bits;

	// request id carried from core to response
	localparam int id_bits = 4;

	// one address word seen two ways
	// raw is used to build line aligned L2 addresses, fields for the lookup
	typedef union packed {
		logic [addr_width-1:0] raw;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [word_bits-1:0] word;
			logic [byte_bits-1:0] byte_off;
		} fields;
	} cache_addr_t;

	// miss handling steps
	// idle       no miss in progress
	// write_back dirty victim goes out to L2
	// fetch_req  read request held until L2 takes it
	// fetch_wait waiting for the line to come back
	// fill       line written into tag and line store
	typedef enum logic [2:0] {
		idle,
		write_back,
		fetch_req,
		fetch_wait,
		fill
	} seq_state_t;

endpackage

/* cache_store/tag_store.sv */
module tag_store (
	input  logic clk,
	input  logic reset,

	// lookup read, combinational
	input  logic [cache_pkg::index_bits-1:0] rd_index_i,

	// one write port, every write marks the set valid
	input  logic wr_en_i,
	input  logic [cache_pkg::index_bits-1:0] wr_index_i,
	input  logic [cache_pkg::tag_bits-1:0] wr_tag_i,
	input  logic wr_dirty_i,

	output logic [cache_pkg::tag_bits-1:0] rd_tag_o,
	output logic rd_valid_o,
	output logic rd_dirty_o
);

	logic [cache_pkg::tag_bits-1:0] tags [cache_pkg::num_sets];
	logic [cache_pkg::num_sets-1:0] valid_bits;
	logic [cache_pkg::num_sets-1:0] dirty_bits;

	// status bits per set
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en_i) begin
			valid_bits[wr_index_i] <= 1'b1;
			dirty_bits[wr_index_i] <= wr_dirty_i;	// fill clears, write hit sets
		end
	end

	// tag array itself
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tags[wr_index_i] <= wr_tag_i;
		end
	end

	assign rd_tag_o = tags[rd_index_i];
	assign rd_valid_o = valid_bits[rd_index_i];
	assign rd_dirty_o = dirty_bits[rd_index_i];

endmodule

/* cache_store/line_store.sv */
module line_store (
	input  logic clk,

	// read of a whole line, combinational
	input  logic [cache_pkg::index_bits-1:0] rd_index_i,

	// single word write from a write hit
	input  logic word_we_i,
	input  logic [cache_pkg::index_bits-1:0] word_index_i,
	input  logic [cache_pkg::word_bits-1:0] word_sel_i,
	input  logic [cache_pkg::data_width-1:0] word_data_i,

	// full line write from a fill
	input  logic fill_we_i,
	input  logic [cache_pkg::index_bits-1:0] fill_index_i,
	input  logic [cache_pkg::line_width-1:0] fill_line_i,

	output logic [cache_pkg::line_width-1:0] rd_line_o
);

	logic [cache_pkg::line_width-1:0] lines [cache_pkg::num_sets];

	// fill and word write are never both active, a fill only follows a miss
	always_ff @(posedge clk) begin
		if (fill_we_i) begin
			lines[fill_index_i] <= fill_line_i;
		end else if (word_we_i) begin
			lines[word_index_i][word_sel_i*cache_pkg::data_width +: cache_pkg::data_width]
				<= word_data_i;
		end
	end

	assign rd_line_o = lines[rd_index_i];

endmodule

/* hw/lookup_stage.sv */
module lookup_stage (
	input  logic clk,
	input  logic reset,

	// core request
	input  logic [cache_pkg::addr_width-1:0] addr_i,
	input  logic [cache_pkg::data_width-1:0] data_i,
	input  logic rw_i,
	input  logic valid_i,
	input  logic [cache_pkg::id_bits-1:0] id_i,
	input  logic seq_busy_i,

	// core response
	output logic stall_o,
	output logic ready_o,
	output logic [cache_pkg::data_width-1:0] data_o,
	output logic [cache_pkg::id_bits-1:0] id_o,

	// held miss, line aligned address
	output logic miss_o,
	output logic [cache_pkg::addr_width-1:0] req_addr_o,

	// store read
	output logic [cache_pkg::index_bits-1:0] rd_index_o,
	input  logic [cache_pkg::tag_bits-1:0] rd_tag_i,
	input  logic rd_valid_i,
	input  logic rd_dirty_i,
	input  logic [cache_pkg::line_width-1:0] rd_line_i,

	// victim seen by the sequencer
	output logic [cache_pkg::tag_bits-1:0] victim_tag_o,
	output logic victim_valid_o,
	output logic victim_dirty_o,
	output logic [cache_pkg::line_width-1:0] victim_line_o,

	// word write on a write hit
	output logic word_we_o,
	output logic [cache_pkg::index_bits-1:0] word_index_o,
	output logic [cache_pkg::word_bits-1:0] word_sel_o,
	output logic [cache_pkg::data_width-1:0] word_data_o,

	// fill request from the sequencer, takes the tag port over
	input  logic fill_we_i,
	input  logic [cache_pkg::index_bits-1:0] fill_index_i,
	input  logic [cache_pkg::tag_bits-1:0] fill_tag_i,

	output logic tag_we_o,
	output logic [cache_pkg::index_bits-1:0] tag_index_o,
	output logic [cache_pkg::tag_bits-1:0] tag_tag_o,
	output logic tag_dirty_o
);

	cache_pkg::cache_addr_t req_addr;
	logic [cache_pkg::data_width-1:0] req_data;
	logic [cache_pkg::id_bits-1:0] req_id;
	logic req_rw, req_valid;
	logic hit, done;

	// hit compare in the cycle after acceptance
	assign hit = req_valid & rd_valid_i & (rd_tag_i == req_addr.fields.tag);
	assign miss_o = req_valid & ~hit;
	assign stall_o = miss_o | seq_busy_i;
	assign done = req_valid & ~stall_o;	// request leaves the stage this cycle

	// request register, held while stalled
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			req_valid <= 1'b0;
		end else if (!stall_o) begin
			req_valid <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i && !stall_o) begin
			req_addr.raw <= addr_i;
			req_data <= data_i;
			req_rw <= rw_i;
			req_id <= id_i;
		end
	end

	// read hits answer one edge later
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ready_o <= 1'b0;
			data_o <= '0;
			id_o <= '0;
		end else begin
			ready_o <= done & ~req_rw;
			if (done && !req_rw) begin
				data_o <= rd_line_i[req_addr.fields.word*cache_pkg::data_width +:
					cache_pkg::data_width];
				id_o <= req_id;
			end
		end
	end

	assign rd_index_o = req_addr.fields.index;
	assign req_addr_o = {req_addr.raw[cache_pkg::addr_width-1:
		cache_pkg::word_bits+cache_pkg::byte_bits],
		{(cache_pkg::word_bits+cache_pkg::byte_bits){1'b0}}};

	assign victim_tag_o = rd_tag_i;
	assign victim_valid_o = rd_valid_i;
	assign victim_dirty_o = rd_dirty_i;
	assign victim_line_o = rd_line_i;

	// write merge into the line
	assign word_we_o = done & req_rw;
	assign word_index_o = req_addr.fields.index;
	assign word_sel_o = req_addr.fields.word;
	assign word_data_o = req_data;

	assign tag_we_o = fill_we_i | word_we_o;
	assign tag_index_o = fill_we_i ? fill_index_i : req_addr.fields.index;
	assign tag_tag_o = fill_we_i ? fill_tag_i : req_addr.fields.tag;
	assign tag_dirty_o = ~fill_we_i;	// fills are clean

endmodule

/* hw/miss_sequencer.sv */
module miss_sequencer (
	input  logic clk,
	input  logic reset,

	// held miss from the lookup stage
	input  logic miss_i,
	input  logic [cache_pkg::addr_width-1:0] req_addr_i,
	input  logic [cache_pkg::tag_bits-1:0] victim_tag_i,
	input  logic victim_valid_i,
	input  logic victim_dirty_i,
	input  logic [cache_pkg::line_width-1:0] victim_line_i,

	// L2 port
	input  logic l2_stall_i,
	input  logic l2_valid_i,
	input  logic [cache_pkg::line_width-1:0] l2_data_i,
	output logic [cache_pkg::addr_width-1:0] l2_addr_o,
	output logic [cache_pkg::line_width-1:0] l2_data_o,
	output logic l2_rw_o,
	output logic l2_valid_o,

	// fill into both stores
	output logic fill_we_o,
	output logic [cache_pkg::index_bits-1:0] fill_index_o,
	output logic [cache_pkg::line_width-1:0] fill_line_o,
	output logic [cache_pkg::tag_bits-1:0] fill_tag_o,
	output logic busy_o
);

	cache_pkg::seq_state_t state, next_state;
	cache_pkg::cache_addr_t req, victim_addr;
	logic [cache_pkg::line_width-1:0] line_buf;

	assign req = req_addr_i;	// stage holds this steady for the whole miss

	// victim sits in the same set under its own tag
	always_comb begin
		victim_addr = '0;
		victim_addr.fields.tag = victim_tag_i;
		victim_addr.fields.index = req.fields.index;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= cache_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			cache_pkg::idle: begin
				if (miss_i) begin
					if (victim_valid_i && victim_dirty_i)
						next_state = cache_pkg::write_back;
					else
						next_state = cache_pkg::fetch_req;
				end
			end
			cache_pkg::write_back: begin
				if (!l2_stall_i)
					next_state = cache_pkg::fetch_req;	// no answer for a write
			end
			cache_pkg::fetch_req: begin
				if (!l2_stall_i)
					next_state = cache_pkg::fetch_wait;
			end
			cache_pkg::fetch_wait: begin
				if (l2_valid_i)
					next_state = cache_pkg::fill;
			end
			cache_pkg::fill: next_state = cache_pkg::idle;	// one cycle only
			default: next_state = cache_pkg::idle;
		endcase
	end

	// returned line, written into the stores on the next cycle
	always_ff @(posedge clk) begin
		if (state == cache_pkg::fetch_wait && l2_valid_i) begin
			line_buf <= l2_data_i;
		end
	end

	// L2 request is a level held by the state itself
	always_comb begin
		l2_valid_o = 1'b0;
		l2_rw_o = 1'b0;
		l2_addr_o = req.raw;
		l2_data_o = '0;
		case (state)
			cache_pkg::write_back: begin
				l2_valid_o = 1'b1;
				l2_rw_o = 1'b1;
				l2_addr_o = victim_addr.raw;
				l2_data_o = victim_line_i;
			end
			cache_pkg::fetch_req: l2_valid_o = 1'b1;
			default: ;
		endcase
	end

	assign fill_we_o = (state == cache_pkg::fill);
	assign fill_index_o = req.fields.index;
	assign fill_tag_o = req.fields.tag;
	assign fill_line_o = line_buf;
	assign busy_o = (state != cache_pkg::idle);

endmodule

/* hw/l1_cache.sv */
module l1_cache (
	input  logic clk,
	input  logic reset,

	// core side
	input  logic [cache_pkg::addr_width-1:0] addr_i,
	input  logic [cache_pkg::data_width-1:0] data_i,
	input  logic rw_i,	// 1 is a write
	input  logic valid_i,
	input  logic [cache_pkg::id_bits-1:0] id_i,
	output logic stall_o,
	output logic ready_o,
	output logic [cache_pkg::data_width-1:0] data_o,
	output logic [cache_pkg::id_bits-1:0] id_o,

	// L2 side
	output logic [cache_pkg::addr_width-1:0] l2_addr_o,
	output logic [cache_pkg::line_width-1:0] l2_data_o,
	output logic l2_rw_o,
	output logic l2_valid_o,
	input  logic l2_stall_i,
	input  logic l2_valid_i,
	input  logic [cache_pkg::line_width-1:0] l2_data_i
);

	// store read side, indexed by the held request
	logic [cache_pkg::index_bits-1:0] rd_index;
	logic [cache_pkg::tag_bits-1:0] rd_tag;
	logic rd_valid, rd_dirty;
	logic [cache_pkg::line_width-1:0] rd_line;

	// write hit port
	logic word_we;
	logic [cache_pkg::index_bits-1:0] word_index;
	logic [cache_pkg::word_bits-1:0] word_sel;
	logic [cache_pkg::data_width-1:0] word_data;

	// tag store write, shared by write hits and fills
	logic tag_we, tag_dirty;
	logic [cache_pkg::index_bits-1:0] tag_index;
	logic [cache_pkg::tag_bits-1:0] tag_wr_tag;

	// stage to sequencer
	logic miss, seq_busy;
	logic [cache_pkg::addr_width-1:0] req_addr;
	logic [cache_pkg::tag_bits-1:0] victim_tag;
	logic victim_valid, victim_dirty;
	logic [cache_pkg::line_width-1:0] victim_line;

	// fill from the sequencer
	logic fill_we;
	logic [cache_pkg::index_bits-1:0] fill_index;
	logic [cache_pkg::tag_bits-1:0] fill_tag;
	logic [cache_pkg::line_width-1:0] fill_line;

	lookup_stage i_lookup_stage (
		.clk(clk), .reset(reset),
		.addr_i(addr_i), .data_i(data_i), .rw_i(rw_i), .valid_i(valid_i), .id_i(id_i),
		.seq_busy_i(seq_busy),
		.stall_o(stall_o), .ready_o(ready_o), .data_o(data_o), .id_o(id_o),
		.miss_o(miss), .req_addr_o(req_addr),
		.rd_index_o(rd_index), .rd_tag_i(rd_tag), .rd_valid_i(rd_valid),
		.rd_dirty_i(rd_dirty), .rd_line_i(rd_line),
		.victim_tag_o(victim_tag), .victim_valid_o(victim_valid),
		.victim_dirty_o(victim_dirty), .victim_line_o(victim_line),
		.word_we_o(word_we), .word_index_o(word_index),
		.word_sel_o(word_sel), .word_data_o(word_data),
		.fill_we_i(fill_we), .fill_index_i(fill_index), .fill_tag_i(fill_tag),
		.tag_we_o(tag_we), .tag_index_o(tag_index),
		.tag_tag_o(tag_wr_tag), .tag_dirty_o(tag_dirty)
	);

	miss_sequencer i_miss_sequencer (
		.clk(clk), .reset(reset),
		.miss_i(miss), .req_addr_i(req_addr),
		.victim_tag_i(victim_tag), .victim_valid_i(victim_valid),
		.victim_dirty_i(victim_dirty), .victim_line_i(victim_line),
		.l2_stall_i(l2_stall_i), .l2_valid_i(l2_valid_i), .l2_data_i(l2_data_i),
		.l2_addr_o(l2_addr_o), .l2_data_o(l2_data_o),
		.l2_rw_o(l2_rw_o), .l2_valid_o(l2_valid_o),
		.fill_we_o(fill_we), .fill_index_o(fill_index),
		.fill_line_o(fill_line), .fill_tag_o(fill_tag),
		.busy_o(seq_busy)
	);

	tag_store i_tag_store (
		.clk(clk), .reset(reset),
		.rd_index_i(rd_index),
		.wr_en_i(tag_we), .wr_index_i(tag_index),
		.wr_tag_i(tag_wr_tag), .wr_dirty_i(tag_dirty),
		.rd_tag_o(rd_tag), .rd_valid_o(rd_valid), .rd_dirty_o(rd_dirty)
	);

	line_store i_line_store (
		.clk(clk),
		.rd_index_i(rd_index),
		.word_we_i(word_we), .word_index_i(word_index),
		.word_sel_i(word_sel), .word_data_i(word_data),
		.fill_we_i(fill_we), .fill_index_i(fill_index), .fill_line_i(fill_line),
		.rd_line_o(rd_line)
	);

endmodule

/* tests/l2_model.sv */
module l2_model (
	input  logic clk,
	input  logic [cache_pkg::addr_width-1:0] addr_i,
	input  logic [cache_pkg::line_width-1:0] data_i,
	input  logic rw_i,
	input  logic valid_i,
	output logic stall_o,
	output logic valid_o,
	output logic [cache_pkg::line_width-1:0] data_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// lines written back by the cache, keyed by line address
	logic [cache_pkg::line_width-1:0] mem [logic [cache_pkg::addr_width-1:0]];
	integer seed = 32'hfc2e_5a69;
	logic take, take_rw, pending;
	logic [cache_pkg::addr_width-1:0] take_addr, fetch_addr;
	logic [cache_pkg::line_width-1:0] take_data;
	int delay;

	// untouched lines hold the address pattern
	function automatic logic [cache_pkg::line_width-1:0] read_line(
		input logic [cache_pkg::addr_width-1:0] line_addr);
		logic [cache_pkg::line_width-1:0] line;
		if (mem.exists(line_addr))
			return mem[line_addr];
		for (int w = 0; w < cache_pkg::words_per_line; w++)
			line[w*cache_pkg::data_width +: cache_pkg::data_width] =
				(line_addr + 4*w) ^ 32'ha5a5_0000;
		return line;
	endfunction

	initial begin
		stall_o = 1'b0;
		valid_o = 1'b0;
		data_o = '0;
		pending = 1'b0;
		delay = 0;
		forever begin
			@(negedge clk);
			take = valid_i && !stall_o;	// request completes at the coming edge
			take_addr = addr_i;
			take_rw = rw_i;
			take_data = data_i;
			@(posedge clk);
			#10;
			valid_o = 1'b0;
			if (pending) begin
				delay--;
				if (delay == 0) begin
					valid_o = 1'b1;	// single cycle answer
					data_o = read_line(fetch_addr);
					pending = 1'b0;
				end
			end
			if (take && take_rw)
				mem[take_addr] = take_data;
			else if (take) begin
				pending = 1'b1;
				fetch_addr = take_addr;
				delay = 1 + $unsigned($random(seed)) % 4;
			end
			stall_o = ($unsigned($random(seed)) % 4) == 0;	// stall about one cycle in four
		end
	end

endmodule

/* tests/tb_l1_cache.sv */
module tb_l1_cache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 200;	// cycles before any wait gives up

	logic clk, reset;
	logic [cache_pkg::addr_width-1:0] addr;
	logic [cache_pkg::data_width-1:0] wdata, rdata;
	logic rw, valid, stall, ready;
	logic [cache_pkg::id_bits-1:0] id, rid;
	logic [cache_pkg::addr_width-1:0] l2_addr;
	logic [cache_pkg::line_width-1:0] l2_wdata, l2_rdata;
	logic l2_rw, l2_req, l2_stall, l2_valid;

	// last value written per word address
	logic [cache_pkg::data_width-1:0] ref_mem [logic [cache_pkg::addr_width-1:0]];
	logic [cache_pkg::id_bits-1:0] exp_id_q [$];
	logic [cache_pkg::data_width-1:0] exp_data_q [$];
	int exp_cnt_q [$];	// edge count of a read that must hit or -1
	int cycle_cnt = 0;
	integer seed = 32'hfc2e_5a69;
	logic [cache_pkg::id_bits-1:0] next_id = '0;

	initial clk = 1'b0;
	always #50 clk = ~clk;
	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	l1_cache i_dut (
		.clk(clk), .reset(reset),
		.addr_i(addr), .data_i(wdata), .rw_i(rw), .valid_i(valid), .id_i(id),
		.stall_o(stall), .ready_o(ready), .data_o(rdata), .id_o(rid),
		.l2_addr_o(l2_addr), .l2_data_o(l2_wdata), .l2_rw_o(l2_rw), .l2_valid_o(l2_req),
		.l2_stall_i(l2_stall), .l2_valid_i(l2_valid), .l2_data_i(l2_rdata)
	);

	l2_model i_l2_model (
		.clk(clk), .addr_i(l2_addr), .data_i(l2_wdata), .rw_i(l2_rw), .valid_i(l2_req),
		.stall_o(l2_stall), .valid_o(l2_valid), .data_o(l2_rdata)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// expected word is the last write or else the L2 address pattern
	function automatic logic [31:0] ref_word(input logic [31:0] a);
		logic [31:0] wa;
		wa = {a[31:2], 2'b00};
		if (ref_mem.exists(wa))
			return ref_mem[wa];
		return wa ^ 32'ha5a5_0000;
	endfunction

	// present one request with inputs changed 10 ns after an edge
	task automatic issue(input logic [31:0] a, input logic wr, input logic [31:0] d,
		input logic must_hit);
		int n;
		addr = a;
		wdata = d;
		rw = wr;
		valid = 1'b1;
		id = next_id;
		n = 0;
		@(negedge clk);
		while (stall && n < wait_limit) begin
			n++;
			@(negedge clk);
		end
		assert (!stall) else fail_run($sformatf("request to %h was never accepted", a));
		if (wr)
			ref_mem[{a[31:2], 2'b00}] = d;
		else begin
			exp_id_q.push_back(next_id);
			exp_data_q.push_back(ref_word(a));
			exp_cnt_q.push_back(must_hit ? cycle_cnt + 1 : -1);
		end
		next_id++;
		@(posedge clk);
		#10;
		valid = 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((n < 2 || exp_id_q.size() != 0 || stall) && n < wait_limit) begin
			@(posedge clk);
			#10;
			n++;
		end
		assert (n < wait_limit) else fail_run("timed out waiting for outstanding requests");
	endtask

	always @(negedge clk) begin : check_responses
		logic [cache_pkg::id_bits-1:0] e_id;
		logic [cache_pkg::data_width-1:0] e_data;
		int e_cnt;
		if (ready) begin
			assert (exp_id_q.size() != 0) else fail_run("ready_o rose with no read outstanding");
			e_id = exp_id_q.pop_front();
			e_data = exp_data_q.pop_front();
			e_cnt = exp_cnt_q.pop_front();
			assert (rid == e_id) else fail_run($sformatf("mismatch id_o: got %h, expected %h",
				rid, e_id));
			assert (rdata == e_data) else fail_run($sformatf(
				"mismatch data_o: got %h, expected %h (id %h)", rdata, e_data, e_id));
			if (e_cnt >= 0)
				assert (cycle_cnt == e_cnt + 1) else fail_run($sformatf(
					"read hit with id %h was not answered one cycle after acceptance", e_id));
		end
	end

	initial begin : main
		int k;
		logic [31:0] a;
		logic w;
		reset = 1'b0;
		addr = '0;
		wdata = '0;
		rw = 1'b0;
		valid = 1'b0;
		id = '0;
		repeat (2) @(posedge clk);
		#10;
		reset = 1'b1;
		assert (!ready && !stall && !l2_req) else fail_run($sformatf(
			"mismatch after reset: ready_o %h stall_o %h l2_valid_o %h, expected 0",
			ready, stall, l2_req));

		// a fresh line misses and the rest of the line then hits
		issue(32'h0000_1000, 1'b0, '0, 1'b0);
		assert (stall) else fail_run("read of a fresh line did not miss");
		for (k = 1; k < 8; k++)
			issue(32'h1000 + k*4, 1'b0, '0, 1'b1);
		drain();

		issue(32'h1008, 1'b1, 32'hdead_beef, 1'b0);
		issue(32'h1008, 1'b0, '0, 1'b1);
		for (k = 0; k < 8; k++)
			issue(32'h1000 + k*4, 1'b0, '0, 1'b1);	// back to back hits
		drain();

		// a same index read evicts the dirty line which is then read back through L2
		for (k = 0; k < 4; k++)
			issue(32'h1000 + k*4, 1'b1, 32'h1111_0000 + k, 1'b0);
		issue(32'h1800, 1'b0, '0, 1'b0);
		issue(32'h1804, 1'b0, '0, 1'b0);
		for (k = 0; k < 4; k++)
			issue(32'h1000 + k*4, 1'b0, '0, 1'b0);
		drain();

		// random mix over four lines of one set
		for (k = 0; k < 300; k++) begin
			a = 32'h1000 + ($unsigned($random(seed)) % 4) * 32'h800
				+ ($unsigned($random(seed)) % 8) * 4;
			w = ($unsigned($random(seed)) % 3) == 0;
			issue(a, w, $random(seed), 1'b0);
		end
		drain();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* project.f */
common/cache_pkg.sv
cache_store/tag_store.sv
cache_store/line_store.sv
hw/lookup_stage.sv
hw/miss_sequencer.sv
hw/l1_cache.sv
tests/l2_model.sv
tests/tb_l1_cache.sv

/* Makefile */
# Verilator build and run for the L1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "TEST FAILED: no pass line in $(LOG)"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
